//--- verilog/dmem_pkg.sv
`default_nettype none

// shared widths, opcodes and byte helpers for the data memory block
package dmem_pkg;

	// architecture widths
	localparam int arch_width     = 32;                 // address and data width
	localparam int lane_count     = arch_width / 8;     // bytes per word
	localparam int dm_words       = 256;                // depth of the word array
	localparam int dm_index_width = $clog2(dm_words);   // word index taken from addr[9:2]

	// store opcodes
	typedef enum logic [2:0] {
		st_sw   = 3'd0, // full word
		st_sh   = 3'd1, // halfword into the lanes picked by addr[1]
		st_sb   = 3'd2, // single byte into lane addr[1:0]
		st_shbr = 3'd3, // halfword with its two bytes swapped
		st_swbr = 3'd4  // word with all four bytes reversed
	} st_op_e;

	// load opcodes
	typedef enum logic [2:0] {
		ld_lw   = 3'd0, // word as stored
		ld_lwbr = 3'd1, // word byte reversed
		ld_lh   = 3'd2, // halfword zero extended
		ld_lha  = 3'd3, // halfword sign extended
		ld_lhbr = 3'd4, // halfword byte swapped then zero extended
		ld_lb   = 3'd5  // byte zero extended
	} ld_op_e;

	// reverse the byte order of a whole word
	// lane 0 trades places with lane 3 and lane 1 with lane 2
	function automatic logic [arch_width-1:0] swap_word(
		input logic [arch_width-1:0] w
	);
		logic [arch_width-1:0] r;
		for (int k = 0; k < lane_count; k++) begin
			r[8*k +: 8] = w[8*(lane_count-1-k) +: 8];
		end
		return r;
	endfunction

	// swap the two bytes of a halfword
	function automatic logic [15:0] swap_half(
		input logic [15:0] h
	);
		return {h[7:0], h[15:8]};
	endfunction

	// pick the halfword addressed by bit 1 of the address
	function automatic logic [15:0] pick_half(
		input logic [arch_width-1:0] w,
		input logic                  hi // addr[1]
	);
		return hi ? w[31:16] : w[15:0];
	endfunction

endpackage

`default_nettype wire

//--- verilog/dmem_ram_if.sv
`default_nettype none

// write port and read data of the word array
// the formatter drives the write side while the array returns the read word
interface dmem_ram_if;
	import dmem_pkg::*;

	logic [lane_count-1:0]     lane_we; // one enable per byte lane
	logic [dm_index_width-1:0] index;   // word index for read and write
	logic [arch_width-1:0]     wdata;   // lane formatted store data
	logic [arch_width-1:0]     rdata;   // registered read word

	// store formatter side
	modport fmt (
		output lane_we,
		output index,
		output wdata
	);

	// array side
	modport mem (
		input  lane_we,
		input  index,
		input  wdata,
		output rdata
	);

endinterface

`default_nettype wire

//--- verilog/dmem_store_align.sv
`default_nettype none

// store formatter
// spreads the store data over the byte lanes and builds the lane mask
// purely combinational so the write lands at the edge ending the request cycle
module dmem_store_align (
	input  logic                            req,   // access strobe
	input  logic                            we,    // high for a store
	input  logic [dmem_pkg::arch_width-1:0] addr,
	input  dmem_pkg::st_op_e                st_op,
	input  logic [dmem_pkg::arch_width-1:0] wdata,
	dmem_ram_if.fmt                         ram
);
	import dmem_pkg::*;

	logic                  st_req;   // store requested this cycle
	logic [1:0]            lane;     // low address bits
	logic [lane_count-1:0] mask;     // lanes touched by the opcode
	logic [arch_width-1:0] lane_dat; // data lined up on the lanes

	assign st_req = req & we;
	assign lane   = addr[1:0];

	// index comes straight from the word address bits
	assign ram.index = addr[dm_index_width+1:2];

	// lane data
	// sub word stores are copied into every slot so the mask alone picks the lanes
	always_comb begin
		case (st_op)
			st_sw:   lane_dat = wdata;
			st_swbr: lane_dat = swap_word(wdata);
			st_sh:   lane_dat = {2{wdata[15:0]}};
			st_shbr: lane_dat = {2{swap_half(wdata[15:0])}};
			st_sb:   lane_dat = {lane_count{wdata[7:0]}};
			default: lane_dat = wdata;
		endcase
	end

	// lane mask from the opcode and the low address bits
	always_comb begin
		case (st_op)
			st_sw,
			st_swbr: mask = '1;                                  // whole word
			st_sh,
			st_shbr: mask = lane[1] ? 4'b1100 : 4'b0011;         // upper or lower half
			st_sb:   mask = 4'b0001 << lane;                     // byte k goes to lane k
			default: mask = '0;                                  // unknown op writes nothing
		endcase
	end

	assign ram.wdata   = lane_dat;
	assign ram.lane_we = mask & {lane_count{st_req}}; // nothing written unless a store

endmodule

`default_nettype wire

//--- verilog/dmem_ram.sv
`default_nettype none

// word array with byte lane write enables
// read is registered so rdata follows the index by one edge
// a read of the word being written returns the old contents
module dmem_ram (
	input  logic    clk,
	dmem_ram_if.mem ram
);
	import dmem_pkg::*;

	// word storage
	logic [arch_width-1:0] mem [dm_words];

	// write every enabled lane
	always_ff @(posedge clk) begin
		for (int k = 0; k < lane_count; k++) begin
			if (ram.lane_we[k]) begin
				mem[ram.index][8*k +: 8] <= ram.wdata[8*k +: 8];
			end
		end
	end

	// synchronous read of the addressed word
	// nonblocking update above means the old word is seen on a same index write
	always_ff @(posedge clk) begin
		ram.rdata <= mem[ram.index];
	end

endmodule

`default_nettype wire

//--- verilog/dmem_load_extend.sv
`default_nettype none

// load extender
// remembers the load opcode and lane bits for the cycle the array read returns
// then picks the lane and extends it to a full word
module dmem_load_extend (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            req,       // access strobe
	input  logic                            we,        // high for a store
	input  logic [dmem_pkg::arch_width-1:0] addr,
	input  dmem_pkg::ld_op_e                ld_op,
	input  logic [dmem_pkg::arch_width-1:0] ram_rdata, // registered word from the array
	output logic [dmem_pkg::arch_width-1:0] rdata,
	output logic                            rvalid
);
	import dmem_pkg::*;

	logic                  ld_req;  // load issued this cycle
	ld_op_e                op_q;    // opcode of the load in flight
	logic [1:0]            lane_q;  // addr[1:0] of the load in flight
	logic                  valid_q; // result due this cycle
	logic [15:0]           half;    // halfword picked by lane_q[1]
	logic [7:0]            byte_s;  // byte picked by lane_q
	logic [arch_width-1:0] ext;     // extended result

	assign ld_req = req & ~we;

	// op and lane bits line up with the array read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_q    <= ld_lw;
			lane_q  <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= ld_req; // one pulse per load
			if (ld_req) begin
				op_q   <= ld_op;
				lane_q <= addr[1:0];
			end
		end
	end

	// lane selection
	assign half   = pick_half(ram_rdata, lane_q[1]);
	assign byte_s = ram_rdata[8*lane_q +: 8];

	// extension per opcode
	always_comb begin
		case (op_q)
			ld_lw:   ext = ram_rdata;
			ld_lwbr: ext = swap_word(ram_rdata);
			ld_lh:   ext = {{(arch_width-16){1'b0}}, half};
			ld_lha:  ext = {{(arch_width-16){half[15]}}, half}; // copy the sign bit up
			ld_lhbr: ext = {{(arch_width-16){1'b0}}, swap_half(half)};
			ld_lb:   ext = {{(arch_width-8){1'b0}}, byte_s};
			default: ext = ram_rdata; // unused codes pass the word through
		endcase
	end

	assign rdata  = ext;     // only meaningful while rvalid is high
	assign rvalid = valid_q;

endmodule

`default_nettype wire

//--- verilog/dmem_top.sv
`default_nettype none

// data memory block
// one access per cycle with stores written at the end of the request cycle
// and load results valid on the following cycle
module dmem_top (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            req,    // one cycle access strobe
	input  logic                            we,     // store when high and load when low
	input  logic [dmem_pkg::arch_width-1:0] addr,   // byte address
	input  dmem_pkg::st_op_e                st_op,  // store size and byte order
	input  dmem_pkg::ld_op_e                ld_op,  // load size and extension
	input  logic [dmem_pkg::arch_width-1:0] wdata,  // store data
	output logic [dmem_pkg::arch_width-1:0] rdata,  // load result
	output logic                            rvalid  // pulse with each load result
);

	// formatter to array port
	dmem_ram_if ram_bus ();

	// store formatting and lane mask
	dmem_store_align u_store_align (
		.req   (req),
		.we    (we),
		.addr  (addr),
		.st_op (st_op),
		.wdata (wdata),
		.ram   (ram_bus.fmt)
	);

	// word array
	dmem_ram u_ram (
		.clk (clk),
		.ram (ram_bus.mem)
	);

	// lane pick and extension of the read word
	dmem_load_extend u_load_extend (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.we        (we),
		.addr      (addr),
		.ld_op     (ld_op),
		.ram_rdata (ram_bus.rdata),
		.rdata     (rdata),
		.rvalid    (rvalid)
	);

endmodule

`default_nettype wire

//--- dv/dmem_tb.sv
`default_nettype none

// testbench for the data memory block
// every store is mirrored in a byte array and every load result is predicted from it
module dmem_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import dmem_pkg::*;

	localparam int clk_period   = 8;
	localparam int reset_cycles = 4;
	localparam int idle_cycles  = 8;
	localparam int part_count   = 300;  // partial store then word read back
	localparam int form_count   = 400;  // word store then one load form
	localparam int stress_count = 2000;
	localparam int stress_words = 16;   // few words so stores and loads collide
	localparam int max_gap      = 3;    // idle cycles between stress requests
	localparam int byte_aw      = dm_index_width + 2; // byte address into the model
	// worst case cycle count of all tests together
	localparam int total_cycles = reset_cycles + 1 + idle_cycles + 2 * dm_words
		+ 2 * part_count + 2 * form_count + stress_count * (2 + max_gap) + 2;
	localparam int margin_ns = 2000;

	logic                  clk;
	logic                  arst_n;
	logic                  req;
	logic                  we;
	logic [arch_width-1:0] addr;
	st_op_e                st_op;
	ld_op_e                ld_op;
	logic [arch_width-1:0] wdata;
	logic [arch_width-1:0] rdata;
	logic                  rvalid;

	logic [7:0]            model_mem [dm_words*lane_count]; // one entry per byte
	logic [arch_width-1:0] exp_q [$];                        // load result due next cycle
	string                 test_name;

	dmem_top DUT (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (req),
		.we     (we),
		.addr   (addr),
		.st_op  (st_op),
		.ld_op  (ld_op),
		.wdata  (wdata),
		.rdata  (rdata),
		.rvalid (rvalid)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// watchdog sized from the cycle budget above
	initial begin
		#(total_cycles * clk_period + margin_ns);
		$display("timeout: the tests did not finish within the expected number of cycles");
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic check(input string name, input logic [arch_width-1:0] expected,
		input logic [arch_width-1:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %08h actual %08h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// model byte address of one lane of the addressed word
	function automatic logic [byte_aw-1:0] lane_addr(input logic [arch_width-1:0] a,
		input logic [1:0] lane);
		return {a[dm_index_width+1:2], lane};
	endfunction

	// store rules with lane k holding data bits 8k+7..8k
	function automatic void model_store(input logic [arch_width-1:0] a, input st_op_e op,
		input logic [arch_width-1:0] d);
		case (op)
			st_sw: begin
				model_mem[lane_addr(a, 2'd0)] = d[7:0];
				model_mem[lane_addr(a, 2'd1)] = d[15:8];
				model_mem[lane_addr(a, 2'd2)] = d[23:16];
				model_mem[lane_addr(a, 2'd3)] = d[31:24];
			end
			st_swbr: begin // lowest data byte lands in lane 3
				model_mem[lane_addr(a, 2'd0)] = d[31:24];
				model_mem[lane_addr(a, 2'd1)] = d[23:16];
				model_mem[lane_addr(a, 2'd2)] = d[15:8];
				model_mem[lane_addr(a, 2'd3)] = d[7:0];
			end
			st_sh: begin
				model_mem[lane_addr(a, {a[1], 1'b0})] = d[7:0];
				model_mem[lane_addr(a, {a[1], 1'b1})] = d[15:8];
			end
			st_shbr: begin
				model_mem[lane_addr(a, {a[1], 1'b0})] = d[15:8];
				model_mem[lane_addr(a, {a[1], 1'b1})] = d[7:0];
			end
			st_sb: model_mem[lane_addr(a, a[1:0])] = d[7:0];
			default: ; // no other store codes are driven
		endcase
	endfunction

	// expected load result from the model bytes
	function automatic logic [arch_width-1:0] model_load(input logic [arch_width-1:0] a,
		input ld_op_e op);
		logic [7:0]            b [lane_count];
		logic [7:0]            lo; // low byte of the addressed halfword
		logic [7:0]            hi;
		logic [arch_width-1:0] r;
		b[0] = model_mem[lane_addr(a, 2'd0)];
		b[1] = model_mem[lane_addr(a, 2'd1)];
		b[2] = model_mem[lane_addr(a, 2'd2)];
		b[3] = model_mem[lane_addr(a, 2'd3)];
		lo   = model_mem[lane_addr(a, {a[1], 1'b0})];
		hi   = model_mem[lane_addr(a, {a[1], 1'b1})];
		case (op)
			ld_lw:   r = {b[3], b[2], b[1], b[0]};
			ld_lwbr: r = {b[0], b[1], b[2], b[3]};
			ld_lh:   r = {16'h0000, hi, lo};
			ld_lha:  r = {{16{hi[7]}}, hi, lo}; // sign from the high byte
			ld_lhbr: r = {16'h0000, lo, hi};
			ld_lb:   r = {24'h000000, model_mem[lane_addr(a, a[1:0])]};
			default: r = 'x;
		endcase
		return r;
	endfunction

	// random upper bits show that address bits above the index are dropped
	function automatic logic [arch_width-1:0] make_addr(input int idx, input int low);
		logic [arch_width-1:0] a;
		a = $urandom();
		a[dm_index_width+1:2] = idx[dm_index_width-1:0];
		a[1:0] = low[1:0];
		return a;
	endfunction

	function automatic st_op_e random_store();
		case ($urandom_range(4, 0))
			0:       return st_sw;
			1:       return st_swbr;
			2:       return st_sh;
			3:       return st_shbr;
			default: return st_sb;
		endcase
	endfunction

	function automatic st_op_e random_partial();
		case ($urandom_range(3, 0))
			0:       return st_sb;
			1:       return st_sh;
			2:       return st_shbr;
			default: return st_swbr;
		endcase
	endfunction

	function automatic ld_op_e random_form();
		case ($urandom_range(4, 0))
			0:       return ld_lwbr;
			1:       return ld_lh;
			2:       return ld_lha;
			3:       return ld_lhbr;
			default: return ld_lb;
		endcase
	endfunction

	// drive one request cycle, then check the result of the load one cycle earlier
	task automatic issue(input logic r, input logic w, input logic [arch_width-1:0] a,
		input st_op_e sop, input ld_op_e lop, input logic [arch_width-1:0] d);
		logic [arch_width-1:0] due;
		logic                  due_valid;
		@(posedge clk);
		req   <= r;
		we    <= w;
		addr  <= a;
		st_op <= sop;
		ld_op <= lop;
		wdata <= d;
		due_valid = exp_q.size() != 0;
		due       = '0;
		if (due_valid) begin
			due = exp_q.pop_front();
		end
		if (r && w) begin
			model_store(a, sop, d);
		end else if (r) begin
			exp_q.push_back(model_load(a, lop)); // sees every store issued before
		end
		@(negedge clk); // outputs settled
		check({test_name, " rvalid"}, 32'(due_valid), 32'(rvalid));
		if (due_valid) begin
			check(test_name, due, rdata);
		end
	endtask

	task automatic idle();
		issue(1'b0, 1'b0, '0, st_sw, ld_lw, '0);
	endtask

	task automatic store(input logic [arch_width-1:0] a, input st_op_e op,
		input logic [arch_width-1:0] d);
		issue(1'b1, 1'b1, a, op, ld_lw, d);
	endtask

	task automatic load(input logic [arch_width-1:0] a, input ld_op_e op);
		issue(1'b1, 1'b0, a, st_sw, op, '0);
	endtask

	initial begin
		logic [arch_width-1:0] a;
		logic [arch_width-1:0] d;
		int                    gap;
		void'($urandom(32'h750cb1b2));
		arst_n    = 1'b0;
		req       = 1'b0;
		we        = 1'b0;
		addr      = '0;
		st_op     = st_sw;
		ld_op     = ld_lw;
		wdata     = '0;
		test_name = "reset";
		repeat (reset_cycles) begin
			@(negedge clk);
			check({test_name, " rvalid"}, '0, 32'(rvalid));
		end
		@(posedge clk);
		arst_n <= 1'b1;

		test_name = "idle"; // nothing issued so rvalid must stay low
		repeat (idle_cycles) begin
			idle();
		end

		test_name = "fill";
		for (int i = 0; i < dm_words; i++) begin
			store(make_addr(i, 0), st_sw, $urandom());
		end
		for (int i = 0; i < dm_words; i++) begin
			load(make_addr(i, 0), ld_lw);
		end

		test_name = "partial";
		for (int i = 0; i < part_count; i++) begin
			a = make_addr(int'($urandom_range(dm_words - 1, 0)), int'($urandom_range(3, 0)));
			store(a, random_partial(), $urandom());
			load(a, ld_lw); // whole word shows which lanes moved
		end

		test_name = "load_forms";
		for (int i = 0; i < form_count; i++) begin
			d = $urandom();
			if (i % 3 == 0) begin
				d = d | 32'h8080_8080; // every byte and halfword negative
			end
			a = make_addr(int'($urandom_range(dm_words - 1, 0)), i % 4);
			store(a, st_sw, d);
			load(a, random_form());
		end

		test_name = "stress";
		for (int i = 0; i < stress_count; i++) begin
			a = make_addr(int'($urandom_range(stress_words - 1, 0)),
				int'($urandom_range(3, 0)));
			case ($urandom_range(3, 0))
				0: begin // load right behind a store to the same word
					store(a, random_store(), $urandom());
					load(a, ld_op_e'(3'($urandom_range(5, 0))));
				end
				1: store(a, random_store(), $urandom());
				default: load(a, ld_op_e'(3'($urandom_range(5, 0))));
			endcase
			gap = int'($urandom_range(max_gap, 0));
			repeat (gap) begin
				idle();
			end
		end

		idle(); // last result
		idle();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dmem_top.f
verilog/dmem_pkg.sv
verilog/dmem_ram_if.sv
verilog/dmem_store_align.sv
verilog/dmem_ram.sv
verilog/dmem_load_extend.sv
verilog/dmem_top.sv
dv/dmem_tb.sv

//--- run.sh
#!/bin/sh
# build and run the data memory testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
	--top-module dmem_tb \
	-f dmem_top.f \
	-o dmem_sim

# a failing run still leaves its log for the search below
status=0
./obj_dir/dmem_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
	echo "run passed"
	exit 0
else
	echo "run failed (exit status $status)"
	exit 1
fi
